// ==== all.f ====
hdl/psgBusPkg.sv
hdl/psgWavePkg.sv
hdl/psgClockEnable.sv
hdl/psgBusArb.sv
hdl/psgChanAddr.sv
hdl/psgFetchCtrl.sv
hdl/psgWaveFetch.sv
tb/psgWaveFetch_props.sv
tb/psgWaveFetchTb.sv

// ==== hdl/psgBusArb.sv ====
module psgBusArb (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            ce,
	input  logic                            busIdle,
	input  logic [psgWavePkg::NUM_CHAN-1:0] chanReq,
	output logic                            grantValid,
	output logic [psgWavePkg::CHAN_W-1:0]   grantChan,
	output logic                            grantNew
);

	logic [psgWavePkg::CHAN_W-1:0] pickChan;
	logic anyReq;
	logic update;

	// lowest numbered requester wins, so scan from the top down
	always_comb begin
		pickChan = '0;
		for (int i = psgWavePkg::NUM_CHAN - 1; i >= 0; i--) begin
			if (chanReq[i]) begin
				pickChan = i[psgWavePkg::CHAN_W-1:0];
			end
		end
	end

	assign anyReq = |chanReq;

	// arbitration only happens between bus cycles
	assign update = ce & busIdle;

	always_ff @(posedge clk) begin
		if (rst) begin
			grantValid <= 1'b0;
			grantChan <= '0;
			grantNew <= 1'b0;
		end else begin
			grantNew <= update & anyReq;
			if (update) begin
				grantValid <= anyReq;
				// nobody asking, keep the last owner number
				if (anyReq) begin
					grantChan <= pickChan;
				end
			end
		end
	end

endmodule

// ==== hdl/psgBusPkg.sv ====
// system memory bus as seen by the wave-table fetcher
package psgBusPkg;

	// ======================================================================
	// bus widths
	// ======================================================================

	// word address into system memory
	localparam int ADDR_W = 16;

	// one sample word per bus cycle
	localparam int DATA_W = 16;

	// ======================================================================
	// bus timing
	// ======================================================================

	// system clocks per clock-enable pulse, arbitration runs at this rate
	localparam int CE_DIV = 4;

endpackage

// ==== hdl/psgChanAddr.sv ====
module psgChanAddr (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            cfgWe,
	input  logic [psgWavePkg::CHAN_W-1:0]   cfgChan,
	input  logic [psgBusPkg::ADDR_W-1:0]    cfgBase,
	input  logic                            cfgEnable,
	input  logic                            advance,
	input  logic [psgWavePkg::CHAN_W-1:0]   grantChan,
	output logic [psgWavePkg::NUM_CHAN-1:0] chanReq,
	output logic [psgBusPkg::ADDR_W-1:0]    chanAddr
);

	logic [psgBusPkg::ADDR_W-1:0] chanBase [psgWavePkg::NUM_CHAN];
	logic [psgWavePkg::OFS_W-1:0] chanOfs [psgWavePkg::NUM_CHAN];
	logic [psgWavePkg::OFS_W-1:0] curOfs;
	logic [psgWavePkg::OFS_W-1:0] nextOfs;

	// base of each wave table
	always_ff @(posedge clk) begin
		if (cfgWe) begin
			chanBase[cfgChan] <= cfgBase;
		end
	end

	// offsets and enables, a config write overrides a step to the same channel
	always_ff @(posedge clk) begin
		if (rst) begin
			chanReq <= '0;
			for (int i = 0; i < psgWavePkg::NUM_CHAN; i++) begin
				chanOfs[i] <= '0;
			end
		end else begin
			if (advance) begin
				chanOfs[grantChan] <= nextOfs;
			end
			if (cfgWe) begin
				chanOfs[cfgChan] <= '0;
				chanReq[cfgChan] <= cfgEnable;
			end
		end
	end

	assign curOfs = chanOfs[grantChan];

	// step through the table and wrap back to the base
	assign nextOfs = (int'(curOfs) == psgWavePkg::WAVE_LEN - 1) ? '0 : curOfs + 1'b1;

	assign chanAddr = chanBase[grantChan]
		+ {{(psgBusPkg::ADDR_W - psgWavePkg::OFS_W){1'b0}}, curOfs};

endmodule

// ==== hdl/psgClockEnable.sv ====
module psgClockEnable (
	input  logic clk,
	input  logic rst,
	output logic ce
);

	logic [$clog2(psgBusPkg::CE_DIV)-1:0] ceCnt;
	logic ceWrap;

	// last count of the divider period
	assign ceWrap = (int'(ceCnt) == psgBusPkg::CE_DIV - 1);

	always_ff @(posedge clk) begin
		if (rst) begin
			ceCnt <= '0;
		end else if (ceWrap) begin
			ceCnt <= '0;
		end else begin
			ceCnt <= ceCnt + 1'b1;
		end
	end

	// one clock wide, once per divider period
	assign ce = ceWrap;

endmodule

// ==== hdl/psgFetchCtrl.sv ====
module psgFetchCtrl (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          grantNew,
	input  logic [psgWavePkg::CHAN_W-1:0] grantChan,
	input  logic [psgBusPkg::ADDR_W-1:0]  chanAddr,
	input  logic                          busAck,
	input  logic [psgBusPkg::DATA_W-1:0]  busDat,
	input  logic                          sampleCredit,
	output logic                          busIdle,
	output logic                          busCyc,
	output logic [psgBusPkg::ADDR_W-1:0]  busAdr,
	output logic                          advance,
	output logic                          sampleValid,
	output logic [psgWavePkg::CHAN_W-1:0] sampleChan,
	output logic [psgBusPkg::DATA_W-1:0]  sampleData
);

	typedef enum logic [1:0] {
		stIdle,
		stCyc,
		stDeliver
	} fetchStateT;

	fetchStateT state;
	logic [psgWavePkg::CREDIT_W-1:0] credits;
	logic start;

	// a fresh grant only turns into a bus cycle if the consumer has room
	assign start = (state == stIdle) && grantNew && (credits != '0);

	// ======================================================================
	// bus cycle FSM
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
		end else begin
			case (state)
				stIdle: begin
					if (start) begin
						state <= stCyc;
					end
				end
				stCyc: begin
					if (busAck) begin
						state <= stDeliver;
					end
				end
				default: begin
					state <= stIdle;
				end
			endcase
		end
	end

	// address and channel are frozen for the whole cycle
	always_ff @(posedge clk) begin
		if (start) begin
			busAdr <= chanAddr;
			sampleChan <= grantChan;
		end
		if ((state == stCyc) && busAck) begin
			sampleData <= busDat;
		end
	end

	// ======================================================================
	// credits toward the sample consumer
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= psgWavePkg::SAMPLE_CREDITS;
		end else begin
			// start and return together leave the count alone
			case ({start, sampleCredit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	assign busIdle = (state == stIdle);
	assign busCyc = (state == stCyc);
	assign sampleValid = (state == stDeliver);

	// offset steps in the same cycle the sample leaves
	assign advance = (state == stDeliver);

endmodule

// ==== hdl/psgWaveFetch.sv ====
module psgWaveFetch (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          cfgWe,
	input  logic [psgWavePkg::CHAN_W-1:0] cfgChan,
	input  logic [psgBusPkg::ADDR_W-1:0]  cfgBase,
	input  logic                          cfgEnable,
	input  logic                          busAck,
	input  logic [psgBusPkg::DATA_W-1:0]  busDat,
	input  logic                          sampleCredit,
	output logic                          busCyc,
	output logic [psgBusPkg::ADDR_W-1:0]  busAdr,
	output logic                          sampleValid,
	output logic [psgWavePkg::CHAN_W-1:0] sampleChan,
	output logic [psgBusPkg::DATA_W-1:0]  sampleData
);

	logic ce;
	logic busIdle;
	logic [psgWavePkg::NUM_CHAN-1:0] chanReq;
	logic [psgWavePkg::CHAN_W-1:0] grantChan;
	logic grantNew;
	logic [psgBusPkg::ADDR_W-1:0] chanAddr;
	logic advance;

	// ======================================================================
	// arbitration
	// ======================================================================

	psgClockEnable i_psgClockEnable (
		.clk (clk),
		.rst (rst),
		.ce  (ce)
	);

	psgBusArb i_psgBusArb (
		.clk        (clk),
		.rst        (rst),
		.ce         (ce),
		.busIdle    (busIdle),
		.chanReq    (chanReq),
		.grantValid (),
		.grantChan  (grantChan),
		.grantNew   (grantNew)
	);

	// ======================================================================
	// channel addressing and bus cycles
	// ======================================================================

	psgChanAddr i_psgChanAddr (
		.clk       (clk),
		.rst       (rst),
		.cfgWe     (cfgWe),
		.cfgChan   (cfgChan),
		.cfgBase   (cfgBase),
		.cfgEnable (cfgEnable),
		.advance   (advance),
		.grantChan (grantChan),
		.chanReq   (chanReq),
		.chanAddr  (chanAddr)
	);

	psgFetchCtrl i_psgFetchCtrl (
		.clk          (clk),
		.rst          (rst),
		.grantNew     (grantNew),
		.grantChan    (grantChan),
		.chanAddr     (chanAddr),
		.busAck       (busAck),
		.busDat       (busDat),
		.sampleCredit (sampleCredit),
		.busIdle      (busIdle),
		.busCyc       (busCyc),
		.busAdr       (busAdr),
		.advance      (advance),
		.sampleValid  (sampleValid),
		.sampleChan   (sampleChan),
		.sampleData   (sampleData)
	);

endmodule

// ==== hdl/psgWavePkg.sv ====
// wave-table channel organisation and sample flow
package psgWavePkg;

	// eight wave-table channels share the bus
	localparam int NUM_CHAN = 8;
	localparam int CHAN_W = 3;

	// words in one wave table, the offset counter wraps after this
	localparam int WAVE_LEN = 16;
	localparam int OFS_W = 4;

	// ======================================================================
	// sample credits toward the consumer
	// ======================================================================

	localparam int CREDIT_W = 3;

	// free sample slots in the consumer after reset
	localparam logic [CREDIT_W-1:0] SAMPLE_CREDITS = 3'd4;

endpackage

// ==== run.sh ====
#!/bin/sh
# build the wave fetcher testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module psgWaveFetchTb -f all.f -o psgWaveFetchSim || exit 1
./obj_dir/psgWaveFetchSim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1
grep -q "ALL TESTS PASSED" sim.log && exit 0 || exit 1

// ==== tb/psgWaveFetchTb.sv ====
module psgWaveFetchTb;

	// three phases of about 40 fetches at up to 20 cycles each, plus margin
	localparam int MAX_CYCLES = 3000;
	localparam int PHASE_FETCHES = 40;

	logic clk;
	logic rst;
	logic cfgWe;
	logic [psgWavePkg::CHAN_W-1:0] cfgChan;
	logic [psgBusPkg::ADDR_W-1:0] cfgBase;
	logic cfgEnable;
	logic busAck;
	logic [psgBusPkg::DATA_W-1:0] busDat;
	logic sampleCredit;
	logic busCyc;
	logic [psgBusPkg::ADDR_W-1:0] busAdr;
	logic sampleValid;
	logic [psgWavePkg::CHAN_W-1:0] sampleChan;
	logic [psgBusPkg::DATA_W-1:0] sampleData;
	integer seed = 39370;
	int cycles = 0;
	int delivered = 0;
	int returned = 0;
	int ackWait = -1;
	int creditWait = 0;
	bit holdCredits = 1'b0;

	psgWaveFetch i_psgWaveFetch (.*);

	bind psgWaveFetch psgWaveFetch_props i_props (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ======================================================================
	// memory model and sample consumer
	// ======================================================================

	always @(negedge clk) begin
		busAck = 1'b0;
		sampleCredit = 1'b0;
		if (sampleValid) begin
			delivered++;
		end
		// word at an address is the address with its bytes swapped
		if (busCyc) begin
			if (ackWait < 0) begin
				ackWait = $random(seed) & 3;
			end
			if (ackWait == 0) begin
				busAck = 1'b1;
				busDat = {busAdr[7:0], busAdr[15:8]};
			end
			ackWait--;
		end
		if (!holdCredits && delivered > returned) begin
			if (creditWait == 0) begin
				sampleCredit = 1'b1;
				returned++;
				creditWait = $random(seed) & 3;
			end else begin
				creditWait--;
			end
		end
	end

	task automatic writeChan(input logic [psgWavePkg::CHAN_W-1:0] chan,
		input logic [psgBusPkg::ADDR_W-1:0] base, input logic en);
		@(negedge clk);
		cfgWe = 1'b1;
		cfgChan = chan;
		cfgBase = base;
		cfgEnable = en;
		@(negedge clk);
		cfgWe = 1'b0;
	endtask

	task automatic waitFetches(input int count);
		int target;
		target = delivered + count;
		while (delivered < target) begin
			@(negedge clk);
		end
	endtask

	task automatic reportAndFinish(input int timeouts);
		int fails;
		fails = i_psgWaveFetch.i_props.errCount;
		$display("summary: %0d assertion failures, %0d timeouts, %0d samples",
			fails, timeouts, delivered);
		if (fails == 0 && timeouts == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			reportAndFinish(1);
		end
	end

	// ======================================================================
	// phases
	// ======================================================================

	initial begin
		rst = 1'b1;
		cfgWe = 1'b0;
		cfgChan = '0;
		cfgBase = '0;
		cfgEnable = 1'b0;
		busAck = 1'b0;
		busDat = '0;
		sampleCredit = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		repeat (10) @(negedge clk);
		writeChan(3'd2, 16'h1230, 1'b1);
		writeChan(3'd5, 16'h4ff8, 1'b1);
		writeChan(3'd7, 16'hfff4, 1'b1);
		waitFetches(PHASE_FETCHES);
		// back-pressure, the consumer keeps all four samples
		holdCredits = 1'b1;
		while (delivered - returned < int'(psgWavePkg::SAMPLE_CREDITS)) begin
			@(negedge clk);
		end
		repeat (60) @(negedge clk);
		writeChan(3'd2, 16'h1230, 1'b0);
		// let any grant taken before the write die out
		repeat (8) @(negedge clk);
		holdCredits = 1'b0;
		waitFetches(PHASE_FETCHES);
		reportAndFinish(0);
	end

endmodule

// ==== tb/psgWaveFetch_props.sv ====
module psgWaveFetch_props (
	input logic                          clk,
	input logic                          rst,
	input logic                          cfgWe,
	input logic [psgWavePkg::CHAN_W-1:0] cfgChan,
	input logic [psgBusPkg::ADDR_W-1:0]  cfgBase,
	input logic                          cfgEnable,
	input logic                          busAck,
	input logic                          sampleCredit,
	input logic                          busCyc,
	input logic [psgBusPkg::ADDR_W-1:0]  busAdr,
	input logic                          sampleValid,
	input logic [psgWavePkg::CHAN_W-1:0] sampleChan,
	input logic [psgBusPkg::DATA_W-1:0]  sampleData
);

	int errCount = 0;
	logic cfgSeen;
	logic [psgBusPkg::ADDR_W-1:0] modelBase [psgWavePkg::NUM_CHAN];
	int modelOfs [psgWavePkg::NUM_CHAN];
	logic [psgWavePkg::NUM_CHAN-1:0] modelEn;
	int outstanding;
	logic found;
	logic [psgWavePkg::CHAN_W-1:0] expChan;
	logic [psgBusPkg::ADDR_W-1:0] expAdr;

	// ======================================================================
	// reference model of the channel setup and the sample flow
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			cfgSeen <= 1'b0;
			modelEn <= '0;
			outstanding <= 0;
			for (int i = 0; i < psgWavePkg::NUM_CHAN; i++) begin
				modelOfs[i] <= 0;
			end
		end else begin
			if (sampleValid) begin
				modelOfs[sampleChan] <= (modelOfs[sampleChan] + 1) % psgWavePkg::WAVE_LEN;
			end
			if (cfgWe) begin
				cfgSeen <= 1'b1;
				modelBase[cfgChan] <= cfgBase;
				modelOfs[cfgChan] <= 0;
				modelEn[cfgChan] <= cfgEnable;
			end
			// delivered minus returned
			outstanding <= outstanding + (sampleValid ? 1 : 0) - (sampleCredit ? 1 : 0);
		end
	end

	// first enabled channel counting up from 0
	always_comb begin
		expChan = '0;
		found = 1'b0;
		for (int i = 0; i < psgWavePkg::NUM_CHAN; i++) begin
			if (modelEn[i] && !found) begin
				expChan = i[psgWavePkg::CHAN_W-1:0];
				found = 1'b1;
			end
		end
	end

	assign expAdr = modelBase[sampleChan] + modelOfs[sampleChan][psgBusPkg::ADDR_W-1:0];

	task automatic noteFail(input string msg);
		errCount++;
		$error("%s", msg);
	endtask

	// ======================================================================
	// properties
	// ======================================================================

	assert property (@(posedge clk) disable iff (rst) !cfgSeen |-> !busCyc && !sampleValid)
		else noteFail("bus activity before the first configuration write");
	assert property (@(posedge clk) disable iff (rst) sampleValid |-> sampleChan == expChan)
		else noteFail($sformatf("ERR sampleChan got %h exp %h",
			$sampled(sampleChan), $sampled(expChan)));
	assert property (@(posedge clk) disable iff (rst) $rose(busCyc) |-> busAdr == expAdr)
		else noteFail($sformatf("ERR busAdr got %h exp %h",
			$sampled(busAdr), $sampled(expAdr)));
	assert property (@(posedge clk) disable iff (rst)
		sampleValid |-> sampleData == {busAdr[7:0], busAdr[15:8]})
		else noteFail($sformatf("ERR sampleData got %h exp %h", $sampled(sampleData),
			$sampled({busAdr[7:0], busAdr[15:8]})));

	// credits toward the consumer
	assert property (@(posedge clk) disable iff (rst)
		outstanding <= int'(psgWavePkg::SAMPLE_CREDITS))
		else noteFail("more samples outstanding than the consumer has room for");
	assert property (@(posedge clk) disable iff (rst)
		outstanding == int'(psgWavePkg::SAMPLE_CREDITS) |-> !busCyc)
		else noteFail("bus cycle running while every credit is outstanding");

	// bus handshake
	assert property (@(posedge clk) disable iff (rst)
		$past(busCyc && !busAck) |-> busAdr == $past(busAdr))
		else noteFail("bus address moved before the acknowledge");
	assert property (@(posedge clk) disable iff (rst) sampleValid == $past(busCyc && busAck))
		else noteFail("sample did not follow the acknowledge by exactly one cycle");

endmodule
